// File: build.f
+incdir+.
mesh_pkg.sv
mesh_fifo.sv
mesh_request_unpack.sv
mesh_slave_mem.sv
mesh_return_pack.sv
mesh_slave_node.sv
tb_mesh_checker.sv
tb_mesh_slave.sv

// File: Makefile
# Verilator build and run for the mesh slave node testbench
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TB_TOP     ?= tb_mesh_slave
RTL_TOP    ?= mesh_slave_node
FILE_LIST  ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All checks passed
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the log decides, not the exit status of the simulation
run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_mesh_slave.sv
/*
 * mesh slave node testbench top
 * clock, reset, seeded random requests, return-link stalls and watchdog
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module tb_mesh_slave;

    localparam int n_fill        = 1 << `MESH_ADDR_WIDTH;
    localparam int n_random      = 2000;
    localparam int n_total       = n_fill + n_random;
    localparam int timeout_ticks = n_total * 40 + 2000;
    localparam int node_x        = 3;
    localparam int node_y        = 2;

    logic                       clk_i;
    logic                       reset_i;
    logic [`MESH_X_WIDTH-1:0]   my_x;
    logic [`MESH_Y_WIDTH-1:0]   my_y;
    mesh_pkg::mesh_req_packet_t link_req_i;
    logic                       link_req_v_i;
    logic                       link_req_ready_o;
    mesh_pkg::mesh_ret_packet_t link_ret_o;
    logic                       link_ret_v_o;
    logic                       link_ret_ready_i;

    int                         seed;
    int                         err_count;
    int                         ret_count;
    int                         exp_count;
    int                         pending;
    mesh_pkg::mesh_req_packet_t req_list [$];
    int                         gap_list [$];

    mesh_slave_node u_dut (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .my_x_i           (my_x),
        .my_y_i           (my_y),
        .link_req_i       (link_req_i),
        .link_req_v_i     (link_req_v_i),
        .link_req_ready_o (link_req_ready_o),
        .link_ret_o       (link_ret_o),
        .link_ret_v_o     (link_ret_v_o),
        .link_ret_ready_i (link_ret_ready_i)
    );

    tb_mesh_checker u_checker (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .my_x_i           (my_x),
        .my_y_i           (my_y),
        .link_req_i       (link_req_i),
        .link_req_v_i     (link_req_v_i),
        .link_req_ready_i (link_req_ready_o),
        .link_ret_i       (link_ret_o),
        .link_ret_v_i     (link_ret_v_o),
        .link_ret_ready_i (link_ret_ready_i),
        .err_count_o      (err_count),
        .ret_count_o      (ret_count),
        .exp_count_o      (exp_count),
        .pending_o        (pending)
    );

    //////////////////////////////////////////////////////////////////////
    // clock and watchdog

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (timeout_ticks) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d clock cycles", timeout_ticks);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // full-mask write with a pattern built from the whole address
    task automatic make_fill_request(input int idx, output mesh_pkg::mesh_req_packet_t pkt);
        logic [7:0] a;
        a         = idx[7:0];
        pkt       = '0;
        pkt.dst_x = my_x;
        pkt.dst_y = my_y;
        pkt.op    = mesh_pkg::op_write;
        pkt.addr  = a;
        pkt.data  = {a, ~a, a ^ 8'ha5, a + 8'h3c};
        pkt.mask  = 4'hf;
    endtask

    task automatic make_random_request(output mesh_pkg::mesh_req_packet_t pkt,
                                       output int gap);
        logic [31:0] r_ctl;
        logic [31:0] r_data;
        logic [31:0] r_pos;
        r_ctl  = $random(seed);
        r_data = $random(seed);
        r_pos  = $random(seed);
        pkt    = '0;
        pkt.op = r_ctl[0] ? mesh_pkg::op_write : mesh_pkg::op_read;
        // half the traffic in a small window for more read-after-write hits
        pkt.addr  = r_ctl[3] ? {2'b00, r_ctl[9:4]} : r_ctl[11:4];
        pkt.data  = r_data;
        pkt.mask  = r_ctl[16] ? 4'hf : r_ctl[15:12];
        pkt.src_x = r_pos[11:8];
        pkt.src_y = r_pos[15:12];
        // about one in eight sent to another node
        if (r_ctl[22:20] == 3'd0) begin
            pkt.dst_x = r_pos[3:0];
            pkt.dst_y = r_pos[7:4];
            if (pkt.dst_x == my_x && pkt.dst_y == my_y) begin
                pkt.dst_x = my_x + 4'd1;
            end
        end else begin
            pkt.dst_x = my_x;
            pkt.dst_y = my_y;
        end
        gap = (r_ctl[27:25] == 3'd0) ? 1 + int'(r_ctl[29:28]) : 0;
    endtask

    // hold the packet until the link takes it
    // ready sampled mid-cycle
    task automatic send_request(input mesh_pkg::mesh_req_packet_t pkt);
        logic taken;
        taken        = 1'b0;
        link_req_i   = pkt;
        link_req_v_i = 1'b1;
        while (!taken) begin
            @(negedge clk_i);
            taken = link_req_ready_o;
            @(posedge clk_i);
            #2;
        end
        link_req_v_i = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // return link back-pressure

    initial begin
        logic [31:0] rnd;
        int          pct;
        int          stall_left;
        logic        in_reset;
        stall_left = 0;
        forever begin
            @(posedge clk_i);
            // reset state as seen at the edge
            in_reset = reset_i;
            #2;
            if (in_reset) begin
                link_ret_ready_i = 1'b0;
            end else if (stall_left > 0) begin
                link_ret_ready_i = 1'b0;
                stall_left--;
            end else begin
                rnd = $random(seed);
                pct = int'(rnd % 100);
                // rare long stall
                if (pct < 2) begin
                    stall_left       = 20 + int'((rnd >> 8) % 40);
                    link_ret_ready_i = 1'b0;
                end else begin
                    link_ret_ready_i = (pct >= 40);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        mesh_pkg::mesh_req_packet_t pkt;
        int                         gap;
        seed             = 27;
        reset_i          = 1'b1;
        my_x             = node_x[`MESH_X_WIDTH-1:0];
        my_y             = node_y[`MESH_Y_WIDTH-1:0];
        link_req_i       = '0;
        link_req_v_i     = 1'b0;
        link_ret_ready_i = 1'b0;

        // whole memory written first and random traffic after
        for (int i = 0; i < n_fill; i++) begin
            make_fill_request(i, pkt);
            req_list.push_back(pkt);
            gap_list.push_back(0);
        end
        for (int i = 0; i < n_random; i++) begin
            make_random_request(pkt, gap);
            req_list.push_back(pkt);
            gap_list.push_back(gap);
        end

        repeat (5) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        foreach (req_list[i]) begin
            send_request(req_list[i]);
            repeat (gap_list[i]) begin
                @(posedge clk_i);
                #2;
            end
        end

        // drain and wait a quiet tail for stray returns
        while (pending != 0) begin
            @(posedge clk_i);
        end
        repeat (20) @(posedge clk_i);

        $display("summary: %0d requests, %0d returns expected, %0d seen, %0d pending, %0d errors",
                 n_total, exp_count, ret_count, pending, err_count);
        if (err_count == 0 && pending == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb_mesh_checker.sv
/*
 * mesh slave node checker
 * memory model and expected-return queue fed from link transfers,
 * compares every outgoing return and counts errors
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module tb_mesh_checker (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [`MESH_X_WIDTH-1:0]   my_x_i,
    input  logic [`MESH_Y_WIDTH-1:0]   my_y_i,

    // incoming link, as seen at the DUT
    input  mesh_pkg::mesh_req_packet_t link_req_i,
    input  logic                       link_req_v_i,
    input  logic                       link_req_ready_i,

    // outgoing link, as seen at the DUT
    input  mesh_pkg::mesh_ret_packet_t link_ret_i,
    input  logic                       link_ret_v_i,
    input  logic                       link_ret_ready_i,

    output int                         err_count_o,
    output int                         ret_count_o,
    output int                         exp_count_o,
    output int                         pending_o
);

    logic [`MESH_DATA_WIDTH-1:0] model [1 << `MESH_ADDR_WIDTH];
    mesh_pkg::mesh_ret_packet_t  exp_q [$];
    int                          err_count = 0;
    int                          ret_count = 0;
    int                          exp_count = 0;
    int                          pending   = 0;

    assign err_count_o = err_count;
    assign ret_count_o = ret_count;
    assign exp_count_o = exp_count;
    assign pending_o   = pending;

    //////////////////////////////////////////////////////////////////////
    // request side

    // memory updated in link order so reads see every earlier write
    task automatic take_request(input mesh_pkg::mesh_req_packet_t req);
        mesh_pkg::mesh_ret_packet_t exp;
        exp.dst_x = req.src_x;
        exp.dst_y = req.src_y;
        if (req.dst_x != my_x_i || req.dst_y != my_y_i) begin
            // misrouted packet leaves memory untouched
            exp.op   = mesh_pkg::op_nack;
            exp.data = '0;
            exp_q.push_back(exp);
            exp_count++;
        end else if (req.op == mesh_pkg::op_write) begin
            for (int i = 0; i < mesh_pkg::mask_width; i++) begin
                if (req.mask[i]) begin
                    model[req.addr][i*8 +: 8] = req.data[i*8 +: 8];
                end
            end
        end else begin
            exp.op   = mesh_pkg::op_read;
            exp.data = model[req.addr];
            exp_q.push_back(exp);
            exp_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // return side

    task automatic check_return(input mesh_pkg::mesh_ret_packet_t got);
        mesh_pkg::mesh_ret_packet_t exp;
        ret_count++;
        if (exp_q.size() == 0) begin
            $display("error @ %0t: return to (%0d,%0d) with no request outstanding",
                     $time, got.dst_x, got.dst_y);
            err_count++;
        end else begin
            exp = exp_q.pop_front();
            if (got !== exp) begin
                $display("error @ %0t: got (%0d,%0d) op %0d %h, expected (%0d,%0d) op %0d %h",
                         $time, got.dst_x, got.dst_y, got.op, got.data,
                         exp.dst_x, exp.dst_y, exp.op, exp.data);
                err_count++;
            end
        end
    endtask

    // link signals sampled mid-cycle where they are settled
    always @(negedge clk_i) begin
        if (!reset_i) begin
            if ($isunknown(link_ret_v_i) || $isunknown(link_req_ready_i)) begin
                $display("error @ %0t: handshake output is unknown after reset", $time);
                err_count++;
            end
            // nothing may leave before the first read or nack
            if (link_ret_v_i && exp_count == 0) begin
                $display("error @ %0t: return valid before any read or nack was accepted",
                         $time);
                err_count++;
            end else if (link_ret_v_i && link_ret_ready_i) begin
                check_return(link_ret_i);
            end
            if (link_req_v_i && link_req_ready_i) begin
                take_request(link_req_i);
            end
            pending = exp_q.size();
        end
    end

endmodule

// File: mesh_slave_node.sv
/*
 * mesh memory slave node top
 * input side, memory and output side between the two links
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module mesh_slave_node (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // node position
    input  logic [`MESH_X_WIDTH-1:0]   my_x_i,
    input  logic [`MESH_Y_WIDTH-1:0]   my_y_i,

    // incoming requests
    input  mesh_pkg::mesh_req_packet_t link_req_i,
    input  logic                       link_req_v_i,
    output logic                       link_req_ready_o,

    // outgoing returns
    output mesh_pkg::mesh_ret_packet_t link_ret_o,
    output logic                       link_ret_v_o,
    input  logic                       link_ret_ready_i
);

    // input side to memory
    mesh_pkg::mesh_local_req_t  local_req;
    logic                       local_req_v;
    logic                       local_req_yumi;

    // memory to output side
    logic                       ret_space;
    logic                       ret_reserve;
    logic                       ret_v;
    mesh_pkg::mesh_ret_packet_t ret_info;

    mesh_request_unpack u_unpack (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .my_x_i           (my_x_i),
        .my_y_i           (my_y_i),
        .link_req_i       (link_req_i),
        .link_req_v_i     (link_req_v_i),
        .link_req_ready_o (link_req_ready_o),
        .local_req_o      (local_req),
        .local_req_v_o    (local_req_v),
        .local_req_yumi_i (local_req_yumi)
    );

    mesh_slave_mem u_mem (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .local_req_i      (local_req),
        .local_req_v_i    (local_req_v),
        .local_req_yumi_o (local_req_yumi),
        .ret_space_i      (ret_space),
        .ret_reserve_o    (ret_reserve),
        .ret_v_o          (ret_v),
        .ret_info_o       (ret_info)
    );

    mesh_return_pack u_pack (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ret_reserve_i    (ret_reserve),
        .ret_space_o      (ret_space),
        .ret_v_i          (ret_v),
        .ret_info_i       (ret_info),
        .link_ret_o       (link_ret_o),
        .link_ret_v_o     (link_ret_v_o),
        .link_ret_ready_i (link_ret_ready_i)
    );

endmodule

// File: mesh_return_pack.sv
/*
 * mesh return output side
 * tracks reserved return slots, queues return packets
 * and drives them onto the outgoing link
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module mesh_return_pack (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // reservation from the memory
    input  logic                       ret_reserve_i,
    output logic                       ret_space_o,

    // return entry from the memory
    input  logic                       ret_v_i,
    input  mesh_pkg::mesh_ret_packet_t ret_info_i,

    // link side
    output mesh_pkg::mesh_ret_packet_t link_ret_o,
    output logic                       link_ret_v_o,
    input  logic                       link_ret_ready_i
);

    localparam int cnt_width = $clog2(`MESH_RET_FIFO_ELS + 1);

    logic [cnt_width-1:0] fifo_count;
    logic [cnt_width-1:0] inflight_r;
    logic [cnt_width:0]   reserved_slots;

    //////////////////////////////////////////////////////////////////////
    // slot reservation

    // reserved in the accept cycle, released when the entry arrives
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            inflight_r <= '0;
        end else begin
            case ({ret_reserve_i, ret_v_i})
                2'b10:   inflight_r <= inflight_r + 1'b1;
                2'b01:   inflight_r <= inflight_r - 1'b1;
                default: inflight_r <= inflight_r;
            endcase
        end
    end

    // queued plus in flight, one spare bit against overflow
    assign reserved_slots = {1'b0, fifo_count} + {1'b0, inflight_r};
    assign ret_space_o    = (reserved_slots < (cnt_width + 1)'(`MESH_RET_FIFO_ELS));

    //////////////////////////////////////////////////////////////////////
    // return queue

    // push always has room thanks to the reservation
    mesh_fifo #(
        .payload_t (mesh_pkg::mesh_ret_packet_t),
        .ELS       (`MESH_RET_FIFO_ELS)
    ) u_ret_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (ret_info_i),
        .v_i     (ret_v_i),
        .ready_o (),
        .data_o  (link_ret_o),
        .v_o     (link_ret_v_o),
        .yumi_i  (link_ret_v_o & link_ret_ready_i),
        .count_o (fifo_count)
    );

endmodule

// File: mesh_slave_mem.sv
/*
 * mesh slave memory
 * single-port word array with byte-masked writes, reads return
 * one cycle after acceptance as a return-valid pulse
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module mesh_slave_mem (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // request from the input side
    input  mesh_pkg::mesh_local_req_t  local_req_i,
    input  logic                       local_req_v_i,
    output logic                       local_req_yumi_o,

    // return slot handshake with the output side
    input  logic                       ret_space_i,
    output logic                       ret_reserve_o,

    // return entry, no back-pressure
    output logic                       ret_v_o,
    output mesh_pkg::mesh_ret_packet_t ret_info_o
);

    localparam int mem_els = 1 << `MESH_ADDR_WIDTH;

    logic [`MESH_DATA_WIDTH-1:0] mem [mem_els];
    logic                        is_write;
    logic                        do_write;
    mesh_pkg::mesh_ret_packet_t  ret_info_r;
    logic                        ret_v_r;

    //////////////////////////////////////////////////////////////////////
    // accept logic

    assign is_write = (local_req_i.op == mesh_pkg::op_write);

    // writes need no return slot
    // reads and nacks wait for a reserved one
    assign local_req_yumi_o = local_req_v_i & (is_write | ret_space_i);
    assign ret_reserve_o    = local_req_yumi_o & ~is_write;
    assign do_write         = local_req_yumi_o & is_write;

    //////////////////////////////////////////////////////////////////////
    // word array

    // only bytes with a set mask bit change
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            for (int i = 0; i < mesh_pkg::mask_width; i++) begin
                if (local_req_i.mask[i]) begin
                    mem[local_req_i.addr][i*8 +: 8] <= local_req_i.data[i*8 +: 8];
                end
            end
        end
    end

    // return entry, captured in the accept cycle
    always_ff @(posedge clk_i) begin
        if (ret_reserve_o) begin
            ret_info_r.dst_x <= local_req_i.src_x;
            ret_info_r.dst_y <= local_req_i.src_y;
            ret_info_r.op    <= local_req_i.op;
            // nack carries zero data
            if (local_req_i.op == mesh_pkg::op_read) begin
                ret_info_r.data <= mem[local_req_i.addr];
            end else begin
                ret_info_r.data <= '0;
            end
        end
    end

    // one-cycle pulse per reserved return
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ret_v_r <= 1'b0;
        end else begin
            ret_v_r <= ret_reserve_o;
        end
    end

    assign ret_v_o    = ret_v_r;
    assign ret_info_o = ret_info_r;

endmodule

// File: mesh_request_unpack.sv
/*
 * mesh request input side
 * buffers link requests, checks the destination against this node
 * and hands local requests to the memory with valid/yumi
 */

`timescale 1ns/100ps

`include "mesh_settings.svh"

module mesh_request_unpack (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // node position
    input  logic [`MESH_X_WIDTH-1:0]  my_x_i,
    input  logic [`MESH_Y_WIDTH-1:0]  my_y_i,

    // link side
    input  mesh_pkg::mesh_req_packet_t link_req_i,
    input  logic                      link_req_v_i,
    output logic                      link_req_ready_o,

    // local side
    output mesh_pkg::mesh_local_req_t local_req_o,
    output logic                      local_req_v_o,
    input  logic                      local_req_yumi_i
);

    mesh_pkg::mesh_req_packet_t head;
    logic                       head_v;
    logic                       dst_match;

    //////////////////////////////////////////////////////////////////////
    // request buffer

    // ready is the FIFO having room
    mesh_fifo #(
        .payload_t (mesh_pkg::mesh_req_packet_t),
        .ELS       (`MESH_REQ_FIFO_ELS)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (link_req_i),
        .v_i     (link_req_v_i),
        .ready_o (link_req_ready_o),
        .data_o  (head),
        .v_o     (head_v),
        .yumi_i  (local_req_yumi_i),
        .count_o ()
    );

    //////////////////////////////////////////////////////////////////////
    // destination check

    // both coordinates have to agree
    assign dst_match = (head.dst_x == my_x_i) && (head.dst_y == my_y_i);

    always_comb begin
        local_req_o.addr  = head.addr;
        local_req_o.data  = head.data;
        local_req_o.mask  = head.mask;
        local_req_o.src_x = head.src_x;
        local_req_o.src_y = head.src_y;
        // misrouted packet turns into a nack for its sender
        if (dst_match) begin
            local_req_o.op = head.op;
        end else begin
            local_req_o.op = mesh_pkg::op_nack;
        end
    end

    // valid straight from the FIFO, one cycle after the link transfer
    assign local_req_v_o = head_v;

endmodule

// File: mesh_fifo.sv
/*
 * synchronous FIFO, circular buffer
 * payload type and depth set by parameters, head shown combinationally
 */

`timescale 1ns/100ps

module mesh_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  ELS       = 4
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  payload_t                 data_i,
    input  logic                     v_i,
    output logic                     ready_o,
    output payload_t                 data_o,
    output logic                     v_o,
    input  logic                     yumi_i,
    output logic [$clog2(ELS+1)-1:0] count_o
);

    localparam int ptr_width = (ELS > 1) ? $clog2(ELS) : 1;
    localparam int cnt_width = $clog2(ELS + 1);

    payload_t             mem [ELS];
    logic [ptr_width-1:0] wr_ptr_r;
    logic [ptr_width-1:0] rd_ptr_r;
    logic [cnt_width-1:0] count_r;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full    = (count_r == cnt_width'(ELS));
    // a pop frees the slot in the same cycle, so full still takes a push
    assign ready_o = ~full | yumi_i;
    assign push    = v_i & ready_o;
    // yumi only counts while the head is valid
    assign pop     = yumi_i & v_o;

    assign v_o     = (count_r != '0);
    assign data_o  = mem[rd_ptr_r];
    assign count_o = count_r;

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_r] <= data_i;
        end
    end

    // pointers and occupancy, wrap at ELS-1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= (wr_ptr_r == ptr_width'(ELS - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= (rd_ptr_r == ptr_width'(ELS - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

endmodule

// File: mesh_pkg.sv
/*
 * mesh slave node types
 * operation encoding, link packets and the local request
 */

`include "mesh_settings.svh"

package mesh_pkg;

    // one mask bit per data byte
    localparam int mask_width = `MESH_DATA_WIDTH / 8;

    // nack is made locally for misrouted packets, never sent on the link
    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_nack  = 2'd2
    } mesh_op_e;

    // incoming request on the link
    typedef struct packed {
        logic [`MESH_X_WIDTH-1:0]    dst_x;
        logic [`MESH_Y_WIDTH-1:0]    dst_y;
        logic [`MESH_X_WIDTH-1:0]    src_x;
        logic [`MESH_Y_WIDTH-1:0]    src_y;
        mesh_op_e                    op;
        logic [`MESH_ADDR_WIDTH-1:0] addr;
        logic [`MESH_DATA_WIDTH-1:0] data;
        logic [mask_width-1:0]       mask;
    } mesh_req_packet_t;

    // request as seen by the memory, destination already checked
    typedef struct packed {
        mesh_op_e                    op;
        logic [`MESH_ADDR_WIDTH-1:0] addr;
        logic [`MESH_DATA_WIDTH-1:0] data;
        logic [mask_width-1:0]       mask;
        logic [`MESH_X_WIDTH-1:0]    src_x;
        logic [`MESH_Y_WIDTH-1:0]    src_y;
    } mesh_local_req_t;

    // return packet, addressed back to the sender
    // data is zero for a nack
    typedef struct packed {
        logic [`MESH_X_WIDTH-1:0]    dst_x;
        logic [`MESH_Y_WIDTH-1:0]    dst_y;
        mesh_op_e                    op;
        logic [`MESH_DATA_WIDTH-1:0] data;
    } mesh_ret_packet_t;

endpackage

// File: mesh_settings.svh
/*
 * mesh slave node sizes
 * coordinate, data and address widths plus FIFO depths
 */

`ifndef MESH_SETTINGS_SVH
`define MESH_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// mesh coordinates

// x and y coordinate widths, one node per (x, y)
`define MESH_X_WIDTH 4
`define MESH_Y_WIDTH 4

//////////////////////////////////////////////////////////////////////
// memory word

// data word, masked per byte
`define MESH_DATA_WIDTH 32
// word address, 256 words
`define MESH_ADDR_WIDTH 8

//////////////////////////////////////////////////////////////////////
// buffering

`define MESH_REQ_FIFO_ELS 4
`define MESH_RET_FIFO_ELS 4

`endif
